/* common/tetris_pkg.sv */
`default_nettype none

package tetris_pkg;

  // well size in cells
  localparam int board_rows_c = 20;
  localparam int board_cols_c = 10;

  // {red, green, blue}, all zero marks an empty cell
  typedef logic [2:0] color_t;

  localparam color_t color_black_c = 3'b000;
  localparam color_t color_white_c = 3'b111;

  // one color per piece
  localparam color_t color_i_c = 3'b011;
  localparam color_t color_o_c = 3'b110;
  localparam color_t color_t_c = 3'b101;
  localparam color_t color_s_c = 3'b010;
  localparam color_t color_z_c = 3'b100;
  localparam color_t color_j_c = 3'b001;
  localparam color_t color_l_c = 3'b111;

  // stored well, index [row][col], row 0 at the top
  typedef color_t [board_rows_c-1:0][board_cols_c-1:0] board_t;

  typedef logic [4:0] row_t;
  typedef logic [3:0] col_t;

  // move command codes
  typedef enum logic [2:0] {
    move_right = 3'd0,
    move_left  = 3'd1,
    move_rot_r = 3'd2,
    move_rot_l = 3'd3,
    move_down  = 3'd4,
    move_none  = 3'd7
  } move_t;

  // listed in spawn order
  typedef enum logic [2:0] {
    p_i = 3'd0,
    p_o = 3'd1,
    p_t = 3'd2,
    p_s = 3'd3,
    p_z = 3'd4,
    p_j = 3'd5,
    p_l = 3'd6
  } piece_t;

  // +1 is a clockwise quarter turn
  typedef logic [1:0] rot_t;

  // one occupied cell inside the 4x4 piece box
  typedef struct packed {
    logic [1:0] row;
    logic [1:0] col;
  } cell_ofs_t;

  typedef cell_ofs_t [3:0] shape_t;

  // box column at spawn, box row is 0
  localparam int spawn_col_c = 3;

endpackage

`default_nettype wire

/* common/display_pkg.sv */
`default_nettype none

package display_pkg;

  // screen coordinate, 640x480 fits
  typedef logic [9:0] pix_t;

  // edge of one square cell in pixels
  localparam int cell_px_c = 16;

  // top-left pixel of cell (0, 0)
  localparam int origin_x_c = 240;
  localparam int origin_y_c = 80;

  // frame one cell wide around the well
  localparam tetris_pkg::color_t border_color_c = tetris_pkg::color_white_c;

endpackage

`default_nettype wire

/* logic/move_decoder.sv */
`default_nettype none

module move_decoder
  import tetris_pkg::*;
(
  input  logic  hz100,
  input  logic  arst_n,
  input  logic  btn_right,
  input  logic  btn_left,
  input  logic  btn_rot_r,
  input  logic  btn_rot_l,
  input  logic  btn_down,
  output move_t move,
  output logic  move_valid
);

  // msb has highest priority
  logic [4:0] btn_raw;
  logic [4:0] sync_1;
  logic [4:0] sync_2;
  logic [4:0] btn_prev;
  logic [4:0] btn_rise;
  move_t      move_next;

  assign btn_raw = {btn_down, btn_right, btn_left, btn_rot_r, btn_rot_l};

  // two stage synchronizer, then last value for edge detect
  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      sync_1   <= '0;
      sync_2   <= '0;
      btn_prev <= '0;
    end else begin
      sync_1   <= btn_raw;
      sync_2   <= sync_1;
      btn_prev <= sync_2;
    end
  end

  // held button stays high, so only the first cycle counts
  assign btn_rise = sync_2 & ~btn_prev;

  // coinciding edges: down wins, rotate left loses
  always_comb begin
    move_next = move_none;
    if (btn_rise[4]) begin
      move_next = move_down;
    end else if (btn_rise[3]) begin
      move_next = move_right;
    end else if (btn_rise[2]) begin
      move_next = move_left;
    end else if (btn_rise[1]) begin
      move_next = move_rot_r;
    end else if (btn_rise[0]) begin
      move_next = move_rot_l;
    end
  end

  // one registered pulse per cycle, third edge after the press
  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      move       <= move_none;
      move_valid <= 1'b0;
    end else begin
      move       <= move_next;
      move_valid <= |btn_rise;
    end
  end

endmodule

`default_nettype wire

/* game/piece_shapes.sv */
`default_nettype none

module piece_shapes
  import tetris_pkg::*;
(
  input  piece_t piece,
  input  rot_t   rot,
  output shape_t shape,
  output color_t color
);

  // packs four (row, col) box offsets
  function automatic shape_t mk(input logic [1:0] r0, c0, r1, c1, r2, c2, r3, c3);
    shape_t s;
    s[0].row = r0;
    s[0].col = c0;
    s[1].row = r1;
    s[1].col = c1;
    s[2].row = r2;
    s[2].col = c2;
    s[3].row = r3;
    s[3].col = c3;
    return s;
  endfunction

  // rotations step clockwise inside the 4x4 box
  always_comb begin
    case ({piece, rot})
      // I: row 1, col 2, row 2, col 1
      {p_i, 2'd0}: shape = mk(2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd3);
      {p_i, 2'd1}: shape = mk(2'd0, 2'd2, 2'd1, 2'd2, 2'd2, 2'd2, 2'd3, 2'd2);
      {p_i, 2'd2}: shape = mk(2'd2, 2'd0, 2'd2, 2'd1, 2'd2, 2'd2, 2'd2, 2'd3);
      {p_i, 2'd3}: shape = mk(2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd3, 2'd1);
      // O never changes
      {p_o, 2'd0},
      {p_o, 2'd1},
      {p_o, 2'd2},
      {p_o, 2'd3}: shape = mk(2'd0, 2'd1, 2'd0, 2'd2, 2'd1, 2'd1, 2'd1, 2'd2);
      {p_t, 2'd0}: shape = mk(2'd0, 2'd1, 2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2);
      {p_t, 2'd1}: shape = mk(2'd0, 2'd1, 2'd1, 2'd1, 2'd1, 2'd2, 2'd2, 2'd1);
      {p_t, 2'd2}: shape = mk(2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd2, 2'd1);
      {p_t, 2'd3}: shape = mk(2'd0, 2'd1, 2'd1, 2'd0, 2'd1, 2'd1, 2'd2, 2'd1);
      {p_s, 2'd0}: shape = mk(2'd0, 2'd1, 2'd0, 2'd2, 2'd1, 2'd0, 2'd1, 2'd1);
      {p_s, 2'd1}: shape = mk(2'd0, 2'd1, 2'd1, 2'd1, 2'd1, 2'd2, 2'd2, 2'd2);
      {p_s, 2'd2}: shape = mk(2'd1, 2'd1, 2'd1, 2'd2, 2'd2, 2'd0, 2'd2, 2'd1);
      {p_s, 2'd3}: shape = mk(2'd0, 2'd0, 2'd1, 2'd0, 2'd1, 2'd1, 2'd2, 2'd1);
      {p_z, 2'd0}: shape = mk(2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd1, 2'd2);
      {p_z, 2'd1}: shape = mk(2'd0, 2'd2, 2'd1, 2'd1, 2'd1, 2'd2, 2'd2, 2'd1);
      {p_z, 2'd2}: shape = mk(2'd1, 2'd0, 2'd1, 2'd1, 2'd2, 2'd1, 2'd2, 2'd2);
      {p_z, 2'd3}: shape = mk(2'd0, 2'd1, 2'd1, 2'd0, 2'd1, 2'd1, 2'd2, 2'd0);
      {p_j, 2'd0}: shape = mk(2'd0, 2'd0, 2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2);
      {p_j, 2'd1}: shape = mk(2'd0, 2'd1, 2'd0, 2'd2, 2'd1, 2'd1, 2'd2, 2'd1);
      {p_j, 2'd2}: shape = mk(2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd2, 2'd2);
      {p_j, 2'd3}: shape = mk(2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd0, 2'd2, 2'd1);
      {p_l, 2'd0}: shape = mk(2'd0, 2'd2, 2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2);
      {p_l, 2'd1}: shape = mk(2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1, 2'd2, 2'd2);
      {p_l, 2'd2}: shape = mk(2'd1, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd2, 2'd0);
      {p_l, 2'd3}: shape = mk(2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd1, 2'd2, 2'd1);
      // unused piece code 7
      default:     shape = mk(2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0);
    endcase
  end

  always_comb begin
    case (piece)
      p_i:     color = color_i_c;
      p_o:     color = color_o_c;
      p_t:     color = color_t_c;
      p_s:     color = color_s_c;
      p_z:     color = color_z_c;
      p_j:     color = color_j_c;
      p_l:     color = color_l_c;
      default: color = color_black_c;
    endcase
  end

endmodule

`default_nettype wire

/* game/tetris_fsm.sv */
`default_nettype none

module tetris_fsm
  import tetris_pkg::*;
#(
  parameter int drop_ticks = 100
) (
  input  logic       hz100,
  input  logic       arst_n,
  input  logic       start,
  input  move_t      move,
  input  logic       move_valid,
  output board_t     board,
  output row_t [3:0] cur_row,
  output col_t [3:0] cur_col,
  output color_t     cur_color,
  output logic       piece_active,
  output logic       game_over,
  output logic [7:0] score
);

  localparam int cnt_w = $clog2(drop_ticks + 1);

  typedef enum logic [2:0] {
    st_idle, st_fall, st_lock, st_clear, st_spawn, st_over
  } state_t;

  state_t            state;
  piece_t            piece;
  piece_t            next_piece;
  rot_t              rot;
  // box top-left, col goes negative for some rotations
  logic signed [5:0] pos_row;
  logic signed [5:0] pos_col;
  logic [cnt_w-1:0]  drop_cnt;
  logic              gravity_tick;
  logic              start_q;
  logic              start_rise;
  move_t             act_move;
  logic signed [5:0] trial_row;
  logic signed [5:0] trial_col;
  rot_t              trial_rot;
  shape_t            trial_shape;
  shape_t            cur_shape;
  logic              trial_fits;
  row_t              scan_row;
  logic              row_full;

  // trial position for the collision check
  piece_shapes u_trial_shape (
    .piece (piece),
    .rot   (trial_rot),
    .shape (trial_shape),
    .color ()
  );

  // current position, shown and locked
  piece_shapes u_cur_shape (
    .piece (piece),
    .rot   (rot),
    .shape (cur_shape),
    .color (cur_color)
  );

  assign piece_active = (state == st_fall);
  assign game_over    = (state == st_over);
  assign start_rise   = start & ~start_q;
  assign gravity_tick = (drop_cnt == cnt_w'(drop_ticks - 1));
  assign next_piece   = (piece == p_l) ? p_i : piece_t'(piece + 3'd1);

  // button move first, gravity waits a cycle on a clash
  always_comb begin
    if (state != st_fall) begin
      act_move = move_none;
    end else if (move_valid) begin
      act_move = move;
    end else if (gravity_tick) begin
      act_move = move_down;
    end else begin
      act_move = move_none;
    end
  end

  always_comb begin
    trial_row = pos_row;
    trial_col = pos_col;
    trial_rot = rot;
    case (act_move)
      move_right: trial_col = pos_col + 6'sd1;
      move_left:  trial_col = pos_col - 6'sd1;
      move_rot_r: trial_rot = rot + 2'd1;
      move_rot_l: trial_rot = rot - 2'd1;
      move_down:  trial_row = pos_row + 6'sd1;
      default:    ;
    endcase
  end

  // every trial cell inside the well and empty
  always_comb begin
    logic signed [5:0] r;
    logic signed [5:0] c;
    trial_fits = 1'b1;
    for (int i = 0; i < 4; i++) begin
      r = trial_row + $signed({4'b0000, trial_shape[i].row});
      c = trial_col + $signed({4'b0000, trial_shape[i].col});
      if (r < 0 || r >= board_rows_c || c < 0 || c >= board_cols_c) begin
        trial_fits = 1'b0;
      end else if (board[r[4:0]][c[3:0]] != color_black_c) begin
        trial_fits = 1'b0;
      end
    end
  end

  // absolute cells, valid while falling
  always_comb begin
    logic signed [5:0] r;
    logic signed [5:0] c;
    for (int i = 0; i < 4; i++) begin
      r = pos_row + $signed({4'b0000, cur_shape[i].row});
      c = pos_col + $signed({4'b0000, cur_shape[i].col});
      cur_row[i] = r[4:0];
      cur_col[i] = c[3:0];
    end
  end

  always_comb begin
    row_full = 1'b1;
    for (int c = 0; c < board_cols_c; c++) begin
      if (board[scan_row][c] == color_black_c) begin
        row_full = 1'b0;
      end
    end
  end

  always_ff @(posedge hz100 or negedge arst_n) begin
    if (!arst_n) begin
      state    <= st_idle;
      board    <= '0;
      score    <= 8'd0;
      piece    <= p_l;
      rot      <= 2'd0;
      pos_row  <= 6'sd0;
      pos_col  <= 6'(spawn_col_c);
      drop_cnt <= '0;
      start_q  <= 1'b0;
      scan_row <= 5'd0;
    end else begin
      start_q <= start;
      case (state)
        st_idle, st_over: begin
          // fresh game, order continues where it stopped
          if (start_rise) begin
            board   <= '0;
            score   <= 8'd0;
            piece   <= next_piece;
            rot     <= 2'd0;
            pos_row <= 6'sd0;
            pos_col <= 6'(spawn_col_c);
            state   <= st_spawn;
          end
        end
        st_spawn: begin
          drop_cnt <= '0;
          state    <= trial_fits ? st_fall : st_over;
        end
        st_fall: begin
          if (gravity_tick) begin
            if (!move_valid) begin
              drop_cnt <= '0;
            end
          end else begin
            drop_cnt <= drop_cnt + 1'b1;
          end
          if (act_move != move_none) begin
            if (trial_fits) begin
              pos_row <= trial_row;
              pos_col <= trial_col;
              rot     <= trial_rot;
            end else if (act_move == move_down) begin
              state <= st_lock;
            end
          end
        end
        st_lock: begin
          for (int i = 0; i < 4; i++) begin
            board[cur_row[i]][cur_col[i]] <= cur_color;
          end
          // next piece loads now, hidden until spawn checks it
          piece    <= next_piece;
          rot      <= 2'd0;
          pos_row  <= 6'sd0;
          pos_col  <= 6'(spawn_col_c);
          scan_row <= row_t'(board_rows_c - 1);
          state    <= st_clear;
        end
        st_clear: begin
          // compact over a full row and rescan the same index
          if (row_full) begin
            for (int r = 1; r < board_rows_c; r++) begin
              if (r <= scan_row) begin
                board[r] <= board[r-1];
              end
            end
            board[0] <= '0;
            if (score != 8'd255) begin
              score <= score + 8'd1;
            end
          end else if (scan_row == 5'd0) begin
            state <= st_spawn;
          end else begin
            scan_row <= scan_row - 5'd1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/board_renderer.sv */
`default_nettype none

module board_renderer
  import tetris_pkg::*;
  import display_pkg::*;
(
  input  pix_t       pix_x,
  input  pix_t       pix_y,
  input  board_t     board,
  input  row_t [3:0] cur_row,
  input  col_t [3:0] cur_col,
  input  color_t     cur_color,
  input  logic       piece_active,
  output color_t     pix_color
);

  // well extent in pixels
  localparam int board_w_c = board_cols_c * cell_px_c;
  localparam int board_h_c = board_rows_c * cell_px_c;

  logic in_board;
  logic in_frame;
  pix_t ofs_x;
  pix_t ofs_y;
  row_t cell_row;
  col_t cell_col;
  logic on_piece;

  assign in_board = (pix_x >= origin_x_c) && (pix_x < origin_x_c + board_w_c) &&
                    (pix_y >= origin_y_c) && (pix_y < origin_y_c + board_h_c);

  // one cell of margin on every side
  assign in_frame = (pix_x >= origin_x_c - cell_px_c) &&
                    (pix_x < origin_x_c + board_w_c + cell_px_c) &&
                    (pix_y >= origin_y_c - cell_px_c) &&
                    (pix_y < origin_y_c + board_h_c + cell_px_c);

  // pixel to cell, only meaningful inside the well
  assign ofs_x    = pix_x - pix_t'(origin_x_c);
  assign ofs_y    = pix_y - pix_t'(origin_y_c);
  assign cell_col = col_t'(ofs_x / pix_t'(cell_px_c));
  assign cell_row = row_t'(ofs_y / pix_t'(cell_px_c));

  always_comb begin
    on_piece = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (piece_active && cur_row[i] == cell_row && cur_col[i] == cell_col) begin
        on_piece = 1'b1;
      end
    end
  end

  // live piece over stored cells, then frame, else black
  always_comb begin
    if (in_board) begin
      pix_color = on_piece ? cur_color : board[cell_row][cell_col];
    end else if (in_frame) begin
      pix_color = border_color_c;
    end else begin
      pix_color = color_black_c;
    end
  end

endmodule

`default_nettype wire

/* logic/tetris_top.sv */
`default_nettype none

module tetris_top
  import tetris_pkg::*;
  import display_pkg::*;
#(
  parameter int drop_ticks = 100
) (
  input  logic       hz100,
  input  logic       arst_n,
  input  logic       start,
  input  logic       btn_right,
  input  logic       btn_left,
  input  logic       btn_rot_r,
  input  logic       btn_rot_l,
  input  logic       btn_down,
  input  pix_t       pix_x,
  input  pix_t       pix_y,
  output color_t     pix_color,
  output logic [7:0] score,
  output logic       game_over,
  output logic       piece_active
);

  move_t      move;
  logic       move_valid;
  board_t     board;
  row_t [3:0] cur_row;
  col_t [3:0] cur_col;
  color_t     cur_color;

  // buttons to one move pulse
  move_decoder u_move_decoder (
    .hz100      (hz100),
    .arst_n     (arst_n),
    .btn_right  (btn_right),
    .btn_left   (btn_left),
    .btn_rot_r  (btn_rot_r),
    .btn_rot_l  (btn_rot_l),
    .btn_down   (btn_down),
    .move       (move),
    .move_valid (move_valid)
  );

  tetris_fsm #(
    .drop_ticks (drop_ticks)
  ) u_tetris_fsm (
    .hz100        (hz100),
    .arst_n       (arst_n),
    .start        (start),
    .move         (move),
    .move_valid   (move_valid),
    .board        (board),
    .cur_row      (cur_row),
    .cur_col      (cur_col),
    .cur_color    (cur_color),
    .piece_active (piece_active),
    .game_over    (game_over),
    .score        (score)
  );

  // pixel lookup, no registers
  board_renderer u_board_renderer (
    .pix_x        (pix_x),
    .pix_y        (pix_y),
    .board        (board),
    .cur_row      (cur_row),
    .cur_col      (cur_col),
    .cur_color    (cur_color),
    .piece_active (piece_active),
    .pix_color    (pix_color)
  );

endmodule

`default_nettype wire

/* tests/tetris_tb.sv */
`default_nettype none

module tetris_tb
  import tetris_pkg::*;
  import display_pkg::*;
;

  localparam int reset_cycles_c = 16;
  localparam int cycles_per_press_c = 60;

  // button vectors {start, down, right, left, rot_r, rot_l}
  localparam logic [5:0] b_start = 6'b100000;
  localparam logic [5:0] b_down  = 6'b010000;
  localparam logic [5:0] b_right = 6'b001000;
  localparam logic [5:0] b_left  = 6'b000100;
  localparam logic [5:0] b_rot_r = 6'b000010;
  localparam logic [5:0] b_rot_l = 6'b000001;

  // one expected cell color
  typedef struct packed {
    logic signed [5:0] row;
    logic signed [5:0] col;
    color_t            color;
  } probe_t;

  // hold keeps the buttons high into the next entry
  typedef struct packed {
    logic [5:0]   btns;
    logic         hold;
    logic [6:0]   reps;
    probe_t [3:0] probe;
    logic [7:0]   score;
    logic         over;
  } step_t;

  logic       hz100 = 1'b0;
  logic       arst_n;
  logic       start;
  logic       btn_right;
  logic       btn_left;
  logic       btn_rot_r;
  logic       btn_rot_l;
  logic       btn_down;
  pix_t       pix_x;
  pix_t       pix_y;
  color_t     pix_color;
  logic [7:0] score;
  logic       game_over;
  logic       piece_active;

  step_t steps[$];
  int    cycles;
  int    cycle_limit;
  int    total_presses;

  tetris_top #(
    .drop_ticks (4000)
  ) u_tetris_top (
    .hz100        (hz100),
    .arst_n       (arst_n),
    .start        (start),
    .btn_right    (btn_right),
    .btn_left     (btn_left),
    .btn_rot_r    (btn_rot_r),
    .btn_rot_l    (btn_rot_l),
    .btn_down     (btn_down),
    .pix_x        (pix_x),
    .pix_y        (pix_y),
    .pix_color    (pix_color),
    .score        (score),
    .game_over    (game_over),
    .piece_active (piece_active)
  );

  always #5 hz100 = ~hz100;

  // watchdog over the whole run
  always @(posedge hz100) begin
    cycles = cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Testbench failed");
      $fatal(1, "timeout, the run did not finish within %0d cycles", cycle_limit);
    end
  end

  task automatic compare_color(input string name, input color_t exp, input color_t act);
    if (act !== exp) begin
      $display("** Error at time %0t: %s expected %b, got %b", $time, name, exp, act);
      $display("Testbench failed");
      $fatal(1, "wrong color at %s", name);
    end
  endtask

  task automatic verify_score(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("** Error at time %0t: %s expected %0d, got %0d", $time, name, exp, act);
      $display("Testbench failed");
      $fatal(1, "wrong %s", name);
    end
  endtask

  task automatic match_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at time %0t: %s expected %b, got %b", $time, name, exp, act);
      $display("Testbench failed");
      $fatal(1, "wrong %s", name);
    end
  endtask

  function automatic probe_t cell_probe(input int r, input int c, input color_t k);
    probe_t p;
    p.row   = r[5:0];
    p.col   = c[5:0];
    p.color = k;
    return p;
  endfunction

  task automatic add_step(input logic [5:0] btns, input logic hold, input int reps,
                          input logic [7:0] score_exp, input logic over_exp,
                          input probe_t p0, input probe_t p1, input probe_t p2,
                          input probe_t p3);
    step_t s;
    s.btns     = btns;
    s.hold     = hold;
    s.reps     = reps[6:0];
    s.probe[0] = p0;
    s.probe[1] = p1;
    s.probe[2] = p2;
    s.probe[3] = p3;
    s.score    = score_exp;
    s.over     = over_exp;
    steps.push_back(s);
  endtask

  task automatic set_buttons(input logic [5:0] b);
    start     = b[5];
    btn_down  = b[4];
    btn_right = b[3];
    btn_left  = b[2];
    btn_rot_r = b[1];
    btn_rot_l = b[0];
  endtask

  // cell center pixel sampled at the falling edge
  task automatic probe_cell(input int row, input int col, input color_t exp);
    int x;
    int y;
    x = origin_x_c + col * cell_px_c + cell_px_c / 2;
    y = origin_y_c + row * cell_px_c + cell_px_c / 2;
    @(posedge hz100);
    #1;
    pix_x = x[9:0];
    pix_y = y[9:0];
    @(negedge hz100);
    compare_color($sformatf("pix_color at row %0d col %0d", row, col), exp, pix_color);
  endtask

  // one press and the wait for a live piece or game over
  task automatic press_buttons(input logic [5:0] b, input logic hold);
    int gap;
    @(posedge hz100);
    #1;
    set_buttons(b);
    // sync, edge and move registers plus the position update
    repeat (5) @(posedge hz100);
    #1;
    if (!hold) begin
      set_buttons(6'b000000);
    end
    while (!(piece_active || game_over)) begin
      @(posedge hz100);
      #1;
    end
    gap = 6 + int'($urandom % 7);
    repeat (gap) @(posedge hz100);
  endtask

  task automatic run_step(input step_t s);
    for (int i = 0; i < int'(s.reps); i++) begin
      press_buttons(s.btns, s.hold);
    end
    for (int i = 0; i < 4; i++) begin
      probe_cell(int'($signed(s.probe[i].row)), int'($signed(s.probe[i].col)),
                 s.probe[i].color);
    end
    verify_score("score", s.score, score);
    match_flag("game_over", s.over, game_over);
    match_flag("piece_active", !s.over, piece_active);
  endtask

  task automatic build_table();
    // I spawns flat in row 1 and walks into the left wall
    add_step(b_start, 1'b0, 1, 8'd0, 1'b0, cell_probe(1, 3, color_i_c),
             cell_probe(1, 6, color_i_c), cell_probe(0, 3, color_black_c),
             cell_probe(1, 7, color_black_c));
    add_step(b_left, 1'b0, 3, 8'd0, 1'b0, cell_probe(1, 0, color_i_c),
             cell_probe(1, 3, color_i_c), cell_probe(1, 4, color_black_c),
             cell_probe(0, 0, color_black_c));
    add_step(b_left, 1'b0, 1, 8'd0, 1'b0, cell_probe(1, 0, color_i_c),
             cell_probe(1, 3, color_i_c), cell_probe(1, 4, color_black_c),
             cell_probe(2, 0, color_black_c));
    // vertical in column 2
    // a held rotate turns only once
    add_step(b_rot_r, 1'b1, 1, 8'd0, 1'b0, cell_probe(0, 2, color_i_c),
             cell_probe(3, 2, color_i_c), cell_probe(1, 0, color_black_c),
             cell_probe(1, 3, color_black_c));
    add_step(b_rot_r, 1'b1, 1, 8'd0, 1'b0, cell_probe(0, 2, color_i_c),
             cell_probe(3, 2, color_i_c), cell_probe(1, 0, color_black_c),
             cell_probe(1, 3, color_black_c));
    add_step(b_rot_r, 1'b0, 1, 8'd0, 1'b0, cell_probe(0, 2, color_i_c),
             cell_probe(3, 2, color_i_c), cell_probe(1, 0, color_black_c),
             cell_probe(1, 3, color_black_c));
    add_step(b_rot_l, 1'b0, 1, 8'd0, 1'b0, cell_probe(1, 0, color_i_c),
             cell_probe(1, 3, color_i_c), cell_probe(0, 2, color_black_c),
             cell_probe(2, 2, color_black_c));
    // down to the floor and a lock that spawns O
    add_step(b_down, 1'b0, 18, 8'd0, 1'b0, cell_probe(19, 0, color_i_c),
             cell_probe(19, 3, color_i_c), cell_probe(18, 0, color_black_c),
             cell_probe(1, 0, color_black_c));
    add_step(b_down, 1'b0, 1, 8'd0, 1'b0, cell_probe(19, 0, color_i_c),
             cell_probe(19, 3, color_i_c), cell_probe(0, 4, color_o_c),
             cell_probe(1, 5, color_o_c));
    // O into columns 8 and 9
    add_step(b_right, 1'b0, 4, 8'd0, 1'b0, cell_probe(0, 8, color_o_c),
             cell_probe(1, 9, color_o_c), cell_probe(0, 4, color_black_c),
             cell_probe(1, 7, color_black_c));
    add_step(b_down, 1'b0, 18, 8'd0, 1'b0, cell_probe(18, 8, color_o_c),
             cell_probe(19, 9, color_o_c), cell_probe(0, 8, color_black_c),
             cell_probe(19, 0, color_i_c));
    add_step(b_down, 1'b0, 1, 8'd0, 1'b0, cell_probe(0, 4, color_t_c),
             cell_probe(1, 3, color_t_c), cell_probe(1, 5, color_t_c),
             cell_probe(19, 8, color_o_c));
    // T flat over columns 4 to 6
    add_step(b_right, 1'b0, 1, 8'd0, 1'b0, cell_probe(0, 5, color_t_c),
             cell_probe(1, 6, color_t_c), cell_probe(1, 3, color_black_c),
             cell_probe(0, 4, color_black_c));
    add_step(b_down, 1'b0, 18, 8'd0, 1'b0, cell_probe(18, 5, color_t_c),
             cell_probe(19, 4, color_t_c), cell_probe(19, 6, color_t_c),
             cell_probe(19, 7, color_black_c));
    add_step(b_down, 1'b0, 1, 8'd0, 1'b0, cell_probe(0, 4, color_s_c),
             cell_probe(1, 3, color_s_c), cell_probe(19, 6, color_t_c),
             cell_probe(19, 7, color_black_c));
    // vertical S closes column 7
    add_step(b_rot_r, 1'b0, 1, 8'd0, 1'b0, cell_probe(2, 5, color_s_c),
             cell_probe(1, 5, color_s_c), cell_probe(0, 5, color_black_c),
             cell_probe(1, 3, color_black_c));
    add_step(b_right, 1'b0, 2, 8'd0, 1'b0, cell_probe(0, 6, color_s_c),
             cell_probe(2, 7, color_s_c), cell_probe(0, 4, color_black_c),
             cell_probe(1, 5, color_black_c));
    add_step(b_down, 1'b0, 17, 8'd0, 1'b0, cell_probe(17, 6, color_s_c),
             cell_probe(19, 7, color_s_c), cell_probe(19, 6, color_t_c),
             cell_probe(18, 5, color_t_c));
    // full row 19 clears and row 18 drops into it
    add_step(b_down, 1'b0, 1, 8'd1, 1'b0, cell_probe(19, 0, color_black_c),
             cell_probe(19, 5, color_t_c), cell_probe(19, 8, color_o_c),
             cell_probe(18, 6, color_s_c));
    // straight drops in the spawn columns until spawn collides
    add_step(b_down, 1'b0, 18, 8'd1, 1'b0, cell_probe(17, 3, color_z_c),
             cell_probe(18, 5, color_z_c), cell_probe(18, 6, color_s_c),
             cell_probe(19, 5, color_t_c));
    add_step(b_down, 1'b0, 77, 8'd1, 1'b0, cell_probe(12, 6, color_i_c),
             cell_probe(10, 4, color_o_c), cell_probe(8, 4, color_t_c),
             cell_probe(2, 3, color_j_c));
    add_step(b_down, 1'b0, 1, 8'd1, 1'b1, cell_probe(0, 5, color_l_c),
             cell_probe(1, 3, color_l_c), cell_probe(12, 3, color_i_c),
             cell_probe(1, 6, color_black_c));
    // new game where O follows the blocked I
    add_step(b_start, 1'b0, 1, 8'd0, 1'b0, cell_probe(0, 4, color_o_c),
             cell_probe(1, 5, color_o_c), cell_probe(19, 5, color_black_c),
             cell_probe(12, 3, color_black_c));
  endtask

  initial begin
    arst_n      = 1'b0;
    pix_x       = '0;
    pix_y       = '0;
    cycles      = 0;
    cycle_limit = 0;
    set_buttons(6'b000000);
    void'($urandom(36));
    build_table();
    total_presses = 0;
    foreach (steps[n]) begin
      total_presses += int'(steps[n].reps);
    end
    cycle_limit = total_presses * cycles_per_press_c + reset_cycles_c;

    repeat (reset_cycles_c) @(posedge hz100);
    #1;
    arst_n = 1'b1;

    // empty well, white frame, black outside
    probe_cell(0, 0, color_black_c);
    probe_cell(19, 9, color_black_c);
    probe_cell(10, 5, color_black_c);
    probe_cell(-1, -1, border_color_c);
    probe_cell(20, 4, border_color_c);
    probe_cell(7, 10, border_color_c);
    probe_cell(7, -1, border_color_c);
    probe_cell(-5, -5, color_black_c);
    verify_score("score", 8'd0, score);
    match_flag("game_over", 1'b0, game_over);
    match_flag("piece_active", 1'b0, piece_active);

    foreach (steps[n]) begin
      run_step(steps[n]);
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
common/tetris_pkg.sv
common/display_pkg.sv
logic/move_decoder.sv
game/piece_shapes.sv
game/tetris_fsm.sv
logic/board_renderer.sv
logic/tetris_top.sv
tests/tetris_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tetris_tb -f sim.f -o tetris_sim; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tetris_sim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Testbench passed" <<< "$output"; then
  exit 0
else
  exit 1
fi
